// ==== Bender.yml ====
package:
  name: burst_ring_buffer

sources:
  # Packages first, then leaf modules, then the top level
  - files:
      - design/ring_geom_pkg.sv
      - design/ring_data_pkg.sv
      - design/wrap_counter.sv
      - design/ring_flow_ctrl.sv
      - design/ring_storage.sv
      - design/burst_ring_buffer.sv

  # Testbench, top module burst_ring_buffer_tb
  - target: test
    files:
      - tests/burst_ring_buffer_tb.sv

// ==== burst_ring_buffer.f ====
design/ring_geom_pkg.sv
design/ring_data_pkg.sv
design/wrap_counter.sv
design/ring_flow_ctrl.sv
design/ring_storage.sv
design/burst_ring_buffer.sv
tests/burst_ring_buffer_tb.sv

// ==== design/burst_ring_buffer.sv ====
// --------------------
// Burst ring buffer top level
// Flow control, read and write counters,
// and entry storage
// --------------------

`timescale 1ns/1ps

module burst_ring_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  ring_geom_pkg::burst_t push_count,
  input  ring_data_pkg::data_t  push_data0,
  input  ring_data_pkg::data_t  push_data1,
  input  ring_geom_pkg::burst_t pop_count,
  output ring_geom_pkg::burst_t push_granted,
  output ring_geom_pkg::burst_t pop_granted,
  output ring_data_pkg::data_t  pop_data0,
  output ring_data_pkg::data_t  pop_data1,
  output ring_geom_pkg::count_t level,
  output logic                  full,
  output logic                  empty
);

  ring_geom_pkg::ptr_t wr_ptr;
  ring_geom_pkg::ptr_t rd_ptr;
  ring_geom_pkg::ptr_t wr_base;
  logic                push_active;
  logic                pop_active;

  // Counters move only on a nonzero grant
  assign push_active = (push_granted != '0);
  assign pop_active  = (pop_granted != '0);

  // Flush restarts the ring at entry 0
  // so the flushed-in burst lands where the read pointer goes
  assign wr_base = flush ? '0 : wr_ptr;

  // --------------------
  // Grants and level
  // --------------------

  ring_flow_ctrl flow_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .push_count   (push_count),
    .pop_count    (pop_count),
    .push_granted (push_granted),
    .pop_granted  (pop_granted),
    .level        (level),
    .full         (full),
    .empty        (empty)
  );

  // --------------------
  // Pointers
  // --------------------

  // Write pointer, reinit still takes the granted push
  wrap_counter #(
    .max_value     (ring_geom_pkg::ring_depth - 1),
    .max_increment (ring_geom_pkg::max_burst)
  ) wr_ptr_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .reinit     (flush),
    .incr_valid (push_active),
    .incr       (push_granted),
    .value      (wr_ptr)
  );

  // Read pointer, pop grant is zero on flush so it restarts at 0
  wrap_counter #(
    .max_value     (ring_geom_pkg::ring_depth - 1),
    .max_increment (ring_geom_pkg::max_burst)
  ) rd_ptr_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .reinit     (flush),
    .incr_valid (pop_active),
    .incr       (pop_granted),
    .value      (rd_ptr)
  );

  // --------------------
  // Entries
  // --------------------

  ring_storage storage_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_ptr   (wr_base),
    .rd_ptr   (rd_ptr),
    .wr_count (push_granted),
    .wr_data0 (push_data0),
    .wr_data1 (push_data1),
    .rd_data0 (pop_data0),
    .rd_data1 (pop_data1)
  );

endmodule : burst_ring_buffer

// ==== design/ring_data_pkg.sv ====
// --------------------
// Ring buffer payload
// Word width and stored word type
// --------------------

package ring_data_pkg;

  // Bits per stored word
  localparam int data_width = 16;

  // One entry of the ring
  typedef logic [data_width-1:0] data_t;

endpackage : ring_data_pkg

// ==== design/ring_flow_ctrl.sv ====
// --------------------
// Ring buffer flow control
// Grants push and pop counts per cycle
// Holds the fill level and full/empty flags
// --------------------

`timescale 1ns/1ps

module ring_flow_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  ring_geom_pkg::burst_t push_count,
  input  ring_geom_pkg::burst_t pop_count,
  output ring_geom_pkg::burst_t push_granted,
  output ring_geom_pkg::burst_t pop_granted,
  output ring_geom_pkg::count_t level,
  output logic                  full,
  output logic                  empty
);

  // Limits at level width
  localparam ring_geom_pkg::count_t depth_lim = ring_geom_pkg::count_t'(ring_geom_pkg::ring_depth);
  localparam ring_geom_pkg::count_t burst_lim = ring_geom_pkg::count_t'(ring_geom_pkg::max_burst);

  ring_geom_pkg::count_t space;
  ring_geom_pkg::count_t push_cap;
  ring_geom_pkg::count_t pop_cap;
  ring_geom_pkg::count_t level_next;

  // Smaller of two level-width values
  function automatic ring_geom_pkg::count_t min_count(input ring_geom_pkg::count_t a,
                                                      input ring_geom_pkg::count_t b);
    return (a < b) ? a : b;
  endfunction

  // --------------------
  // Grants
  // --------------------

  // Free room as seen at the start of the cycle
  // A same-cycle pop frees nothing yet
  // Flush empties the ring, so all entries count as free
  assign space = flush ? depth_lim : depth_lim - level;

  // Push limited by burst size and then by room
  assign push_cap = min_count(min_count(ring_geom_pkg::count_t'(push_count), burst_lim), space);

  // Pop limited by burst size and by what is stored
  // Nothing is popped during a flush
  assign pop_cap = flush ? '0
                         : min_count(min_count(ring_geom_pkg::count_t'(pop_count), burst_lim),
                                     level);

  // Both caps are at most max_burst and fit the burst width
  assign push_granted = ring_geom_pkg::burst_t'(push_cap);
  assign pop_granted  = ring_geom_pkg::burst_t'(pop_cap);

  // --------------------
  // Level and flags
  // --------------------

  // Flush drops old contents and keeps only the new words
  assign level_next = flush ? push_cap : level + push_cap - pop_cap;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      level <= level_next;
      // Flags are decoded from the next level so they line up with it
      full  <= (level_next == depth_lim);
      empty <= (level_next == '0);
    end
  end

endmodule : ring_flow_ctrl

// ==== design/ring_geom_pkg.sv ====
// --------------------
// Ring buffer geometry
// Entry count and per-cycle burst limit
// Widths and vector types for entry index,
// fill level and per-cycle word counts
// --------------------

package ring_geom_pkg;

  // Number of entries in the ring, not a power of two
  localparam int ring_depth = 6;

  // Most words moved on each side in one cycle
  localparam int max_burst = 2;

  // --------------------
  // Derived widths
  // --------------------

  // Entry index, 0 to ring_depth-1
  localparam int ptr_width = $clog2(ring_depth);

  // Fill level, 0 to ring_depth inclusive
  localparam int count_width = $clog2(ring_depth + 1);

  // Word count per cycle, wide enough for max_burst
  // A request of 3 fits and gets limited by the controller
  localparam int burst_width = $clog2(max_burst + 1);

  // --------------------
  // Types
  // --------------------

  typedef logic [ptr_width-1:0] ptr_t;

  typedef logic [count_width-1:0] count_t;

  typedef logic [burst_width-1:0] burst_t;

endpackage : ring_geom_pkg

// ==== design/ring_storage.sv ====
// --------------------
// Ring buffer entry storage
// Two write lanes at wr_ptr and the index after
// Two show-ahead read lanes at rd_ptr and the index after
// --------------------

`timescale 1ns/1ps

module ring_storage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ring_geom_pkg::ptr_t   wr_ptr,
  input  ring_geom_pkg::ptr_t   rd_ptr,
  input  ring_geom_pkg::burst_t wr_count,
  input  ring_data_pkg::data_t  wr_data0,
  input  ring_data_pkg::data_t  wr_data1,
  output ring_data_pkg::data_t  rd_data0,
  output ring_data_pkg::data_t  rd_data1
);

  localparam ring_geom_pkg::ptr_t last_index =
    ring_geom_pkg::ptr_t'(ring_geom_pkg::ring_depth - 1);

  ring_data_pkg::data_t entries [ring_geom_pkg::ring_depth];

  ring_geom_pkg::ptr_t wr_ptr_inc;
  ring_geom_pkg::ptr_t rd_ptr_inc;
  logic                wr_lane0;
  logic                wr_lane1;

  // Following index around the ring, last entry back to 0
  function automatic ring_geom_pkg::ptr_t next_index(input ring_geom_pkg::ptr_t idx);
    return (idx == last_index) ? '0 : idx + 1'b1;
  endfunction

  assign wr_ptr_inc = next_index(wr_ptr);
  assign rd_ptr_inc = next_index(rd_ptr);

  // Lane 0 takes the older word of a burst
  assign wr_lane0 = (wr_count != '0);
  assign wr_lane1 = (wr_count >= ring_geom_pkg::burst_t'(2));

  // --------------------
  // Write side
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ring_geom_pkg::ring_depth; i++) begin
        entries[i] <= '0;
      end
    end else begin
      for (int i = 0; i < ring_geom_pkg::ring_depth; i++) begin
        // The two lanes always hit different entries
        if (wr_lane0 && (wr_ptr == ring_geom_pkg::ptr_t'(i))) begin
          entries[i] <= wr_data0;
        end else if (wr_lane1 && (wr_ptr_inc == ring_geom_pkg::ptr_t'(i))) begin
          entries[i] <= wr_data1;
        end
      end
    end
  end

  // --------------------
  // Read side
  // --------------------

  // Head and the word behind it, no read latency
  assign rd_data0 = entries[rd_ptr];
  assign rd_data1 = entries[rd_ptr_inc];

endmodule : ring_storage

// ==== design/wrap_counter.sv ====
// --------------------
// Wrapping counter with variable increment
// Wraps past zero at max_value, any max_value
// Reinit restarts at zero and keeps the increment
// --------------------

`timescale 1ns/1ps

module wrap_counter #(
  parameter int max_value = 1,
  parameter int max_increment = 1,
  localparam int value_width = $clog2(max_value + 1),
  localparam int incr_width = $clog2(max_increment + 1)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reinit,
  input  logic                  incr_valid,
  input  logic [incr_width-1:0] incr,
  output logic [value_width-1:0] value
);

  // One extra bit holds value plus increment before wrapping
  localparam int sum_width = value_width + 1;

  // Modulus of the count
  localparam logic [sum_width-1:0] wrap_amount = sum_width'(max_value + 1);

  // Power-of-two modulus wraps by truncation alone
  localparam bit wrap_is_pow2 = ((max_value + 1) & max_value) == 0;

  logic [sum_width-1:0]   base;
  logic [sum_width-1:0]   step;
  logic [sum_width-1:0]   sum;
  logic [value_width-1:0] value_next;

  // Reinit starts from zero, increment still applies
  assign base = reinit ? '0 : sum_width'(value);
  assign step = incr_valid ? sum_width'(incr) : '0;
  assign sum  = base + step;

  if (wrap_is_pow2) begin : gen_pow2
    // Dropping the carry bit is the modulo
    assign value_next = sum[value_width-1:0];
  end else begin : gen_non_pow2
    logic [sum_width-1:0] sum_wrapped;

    // At most one wrap since the increment never exceeds max_value
    assign sum_wrapped = sum - wrap_amount;
    assign value_next  = (sum > sum_width'(max_value)) ? sum_wrapped[value_width-1:0]
                                                       : sum[value_width-1:0];
  end

  // Load only when something changes the count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= '0;
    end else if (incr_valid || reinit) begin
      value <= value_next;
    end
  end

endmodule : wrap_counter

// ==== tests/burst_ring_buffer_tb.sv ====
// --------------------
// Testbench for the burst ring buffer
// Clock, reset and per-cycle stimulus
// Queue model of the grant rules and level update
// Per-cycle comparison, directed checks, watchdog
// --------------------

`timescale 1ns/1ps

module burst_ring_buffer_tb;

  localparam int clk_period = 40;
  localparam int reset_cycles = 3;
  // Room for the directed sequence
  localparam int directed_cycles = 80;
  localparam int random_cycles = 400;
  localparam int total_cycles = reset_cycles + directed_cycles + random_cycles;

  logic                  clk;
  logic                  rst_n;
  logic                  flush;
  ring_geom_pkg::burst_t push_count;
  ring_data_pkg::data_t  push_data0;
  ring_data_pkg::data_t  push_data1;
  ring_geom_pkg::burst_t pop_count;
  ring_geom_pkg::burst_t push_granted;
  ring_geom_pkg::burst_t pop_granted;
  ring_data_pkg::data_t  pop_data0;
  ring_data_pkg::data_t  pop_data1;
  ring_geom_pkg::count_t level;
  logic                  full;
  logic                  empty;

  // Expected ring contents, head at index 0
  ring_data_pkg::data_t model_q[$];
  int                   errors = 0;
  int                   cycles_checked = 0;
  logic [31:0]          rng_state = 32'hb6d7;
  ring_data_pkg::data_t tag = 16'h1000;

  burst_ring_buffer dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .push_count   (push_count),
    .push_data0   (push_data0),
    .push_data1   (push_data1),
    .pop_count    (pop_count),
    .push_granted (push_granted),
    .pop_granted  (pop_granted),
    .pop_data0    (pop_data0),
    .pop_data1    (pop_data1),
    .level        (level),
    .full         (full),
    .empty        (empty)
  );

  always #(clk_period / 2) clk = ~clk;

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int min_of(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

  // Grant rules on the model queue, queue then holds the state after the edge
  function automatic void model_step(input logic fl, input int pc, input int oc,
                                     input ring_data_pkg::data_t d0,
                                     input ring_data_pkg::data_t d1,
                                     output int exp_push, output int exp_pop);
    int space;
    space = fl ? ring_geom_pkg::ring_depth : ring_geom_pkg::ring_depth - model_q.size();
    exp_push = min_of(min_of(pc, ring_geom_pkg::max_burst), space);
    exp_pop = fl ? 0 : min_of(min_of(oc, ring_geom_pkg::max_burst), model_q.size());
    if (fl) begin
      model_q.delete();
    end
    for (int i = 0; i < exp_pop; i++) begin
      void'(model_q.pop_front());
    end
    // Lane 0 is the older word
    if (exp_push >= 1) model_q.push_back(d0);
    if (exp_push >= 2) model_q.push_back(d1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic drive_cycle(input logic fl, input int pc, input int oc,
                             input ring_data_pkg::data_t d0, input ring_data_pkg::data_t d1);
    @(posedge clk);
    #2;
    flush      = fl;
    push_count = ring_geom_pkg::burst_t'(pc);
    pop_count  = ring_geom_pkg::burst_t'(oc);
    push_data0 = d0;
    push_data1 = d1;
  endtask

  // Directed traffic with counting words, then settle for grant checks
  task automatic drive_tagged(input logic fl, input int pc, input int oc);
    drive_cycle(fl, pc, oc, tag, tag + 1'b1);
    tag = tag + 16'd2;
    #5;
  endtask

  // --------------------
  // Comparison against the model
  // --------------------

  // Falling edge sits mid-cycle, well clear of input changes
  always @(negedge clk) begin : compare_outputs
    int exp_push;
    int exp_pop;
    int lvl;
    if (rst_n) begin
      lvl = model_q.size();
      check_value("level", lvl, level);
      check_value("full", lvl == ring_geom_pkg::ring_depth, full);
      check_value("empty", lvl == 0, empty);
      // Read lanes are defined only as deep as the level
      if (lvl >= 1) check_value("pop_data0", model_q[0], pop_data0);
      if (lvl >= 2) check_value("pop_data1", model_q[1], pop_data1);
      model_step(flush, push_count, pop_count, push_data0, push_data1, exp_push, exp_pop);
      check_value("push_granted", exp_push, push_granted);
      check_value("pop_granted", exp_pop, pop_granted);
      cycles_checked++;
    end
  end

  // --------------------
  // Watchdog
  // --------------------

  initial begin : watchdog
    #((total_cycles + 50) * clk_period);
    $display("Watchdog timeout, the run went past its planned length");
    $display("Checks failed");
    $finish;
  end

  // --------------------
  // Stimulus
  // --------------------

  initial begin : stimulus
    ring_data_pkg::data_t fw0;
    ring_data_pkg::data_t fw1;
    logic [31:0]          r;
    clk        = 1'b0;
    rst_n      = 1'b0;
    flush      = 1'b0;
    push_count = '0;
    pop_count  = '0;
    push_data0 = '0;
    push_data1 = '0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    #5;

    // Empty after reset, pop of 2 gets nothing
    check_value("level", 0, level);
    check_value("empty", 1, empty);
    check_value("full", 0, full);
    drive_tagged(1'b0, 0, 2);
    check_value("pop_granted", 0, pop_granted);

    // Steady double bursts, pointers wrap many times
    drive_tagged(1'b0, 2, 0);
    repeat (20) drive_tagged(1'b0, 2, 2);
    drive_tagged(1'b0, 0, 2);

    // Overfill from level 5
    drive_tagged(1'b0, 2, 0);
    drive_tagged(1'b0, 2, 0);
    drive_tagged(1'b0, 1, 0);
    drive_tagged(1'b0, 2, 0);
    check_value("push_granted", 1, push_granted);
    drive_tagged(1'b0, 2, 0);
    check_value("full", 1, full);
    check_value("push_granted", 0, push_granted);
    // Same-cycle pop frees no room yet
    drive_tagged(1'b0, 2, 2);
    check_value("push_granted", 0, push_granted);
    check_value("pop_granted", 2, pop_granted);

    // Over-drain and requests of 3
    drive_tagged(1'b0, 0, 2);
    drive_tagged(1'b0, 0, 1);
    drive_tagged(1'b0, 0, 2);
    check_value("pop_granted", 1, pop_granted);
    drive_tagged(1'b0, 3, 0);
    check_value("empty", 1, empty);
    check_value("push_granted", 2, push_granted);
    drive_tagged(1'b0, 3, 0);
    drive_tagged(1'b0, 0, 3);
    check_value("pop_granted", 2, pop_granted);

    // Flush at level 3 with a double push
    drive_tagged(1'b0, 1, 0);
    fw0 = tag;
    fw1 = tag + 1'b1;
    drive_tagged(1'b1, 2, 2);
    check_value("pop_granted", 0, pop_granted);
    check_value("push_granted", 2, push_granted);
    drive_tagged(1'b0, 0, 0);
    check_value("level", 2, level);
    check_value("pop_data0", fw0, pop_data0);
    check_value("pop_data1", fw1, pop_data1);

    // Random mix, flush in about 1 of 32 cycles
    repeat (random_cycles) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      rng_state = xorshift32(rng_state);
      drive_cycle(r[4:0] == 5'd0, r[9:8], r[11:10], rng_state[15:0], rng_state[31:16]);
    end

    drive_cycle(1'b0, 0, 0, '0, '0);
    @(negedge clk);
    #1;
    $display("Errors: %0d, cycles checked: %0d", errors, cycles_checked);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : burst_ring_buffer_tb
